// File: logic/alu_pkg.sv
`default_nettype none

package alu_pkg;

    localparam int WORD_W = 16;   // Full operand width
    localparam int BYTE_W = 8;    // Narrow operand width

    typedef enum logic [4:0] {
        ALU_OP_ADD   = 5'd0,
        ALU_OP_ADDC  = 5'd1,
        ALU_OP_INC   = 5'd2,
        ALU_OP_SUB   = 5'd3,
        ALU_OP_SUBC  = 5'd4,
        ALU_OP_CMP   = 5'd5,
        ALU_OP_DEC   = 5'd6,
        ALU_OP_NEG   = 5'd7,
        ALU_OP_AND   = 5'd8,
        ALU_OP_OR    = 5'd9,
        ALU_OP_XOR   = 5'd10,
        ALU_OP_NOT   = 5'd11,
        ALU_OP_SET1  = 5'd12,
        ALU_OP_CLR1  = 5'd13,
        ALU_OP_TEST1 = 5'd14,
        ALU_OP_NOT1  = 5'd15,
        ALU_OP_ROL   = 5'd16,
        ALU_OP_ROR   = 5'd17,
        ALU_OP_SHL   = 5'd18,
        ALU_OP_SHR   = 5'd19,
        ALU_OP_SHRA  = 5'd20   // Codes 21 to 31 are illegal
    } alu_op_e;

    // Flag word, high bit first
    typedef struct packed {
        logic V;
        logic S;
        logic Z;
        logic AC;
        logic P;
        logic CY;
    } flags_t;

    typedef enum logic [1:0] {
        CLASS_ARITH   = 2'd0,
        CLASS_BITWISE = 2'd1,
        CLASS_SHIFT   = 2'd2,
        CLASS_NONE    = 2'd3
    } alu_class_e;

    // Which unit serves an operation
    function automatic alu_class_e op_class(input alu_op_e op);
        case (op)
            ALU_OP_ADD, ALU_OP_ADDC, ALU_OP_INC, ALU_OP_SUB, ALU_OP_SUBC,
            ALU_OP_CMP, ALU_OP_DEC, ALU_OP_NEG:                     return CLASS_ARITH;
            ALU_OP_AND, ALU_OP_OR, ALU_OP_XOR, ALU_OP_NOT, ALU_OP_SET1,
            ALU_OP_CLR1, ALU_OP_TEST1, ALU_OP_NOT1:                 return CLASS_BITWISE;
            ALU_OP_ROL, ALU_OP_ROR, ALU_OP_SHL, ALU_OP_SHR,
            ALU_OP_SHRA:                                            return CLASS_SHIFT;
            default:                                                return CLASS_NONE;
        endcase
    endfunction

    // Top bit at the active width
    function automatic logic msb(input logic [WORD_W-1:0] x, input logic wide);
        return wide ? x[WORD_W-1] : x[BYTE_W-1];
    endfunction

endpackage

`default_nettype wire

// File: logic/alu_addsub.sv
`timescale 1ns/1ps
`default_nettype none

module alu_addsub (
    input  wire alu_pkg::alu_op_e               operation,
    input  wire [alu_pkg::WORD_W-1:0]           ta,
    input  wire [alu_pkg::WORD_W-1:0]           tb,
    input  wire                                 wide,
    input  wire alu_pkg::flags_t                flags_in,
    output logic [alu_pkg::WORD_W-1:0]          res,
    output logic                                cy,
    output logic                                ac,
    output logic                                v,
    output logic                                psz
);

    localparam int W = alu_pkg::WORD_W;
    localparam int B = alu_pkg::BYTE_W;

    logic [W-1:0] opnd;      // Second operand after INC/DEC and carry-in handling
    logic [W:0]   sum;
    logic [W-1:0] diff;
    logic [W-1:0] neg;
    logic [4:0]   nib_sum;
    logic [W-1:0] ta_act;
    logic [W-1:0] opnd_act;

    always_comb begin
        case (operation)
            alu_pkg::ALU_OP_INC,
            alu_pkg::ALU_OP_DEC:  opnd = W'(1);
            alu_pkg::ALU_OP_ADDC,
            alu_pkg::ALU_OP_SUBC: opnd = tb + {{(W-1){1'b0}}, flags_in.CY};
            default:              opnd = tb;
        endcase
    end

    assign sum      = {1'b0, ta} + {1'b0, opnd};
    assign diff     = ta - opnd;
    assign neg      = '0 - ta;
    assign nib_sum  = {1'b0, ta[3:0]} + {1'b0, opnd[3:0]};

    // Operands cut to the active width, for borrow and zero tests
    assign ta_act   = wide ? ta   : {{(W-B){1'b0}}, ta[B-1:0]};
    assign opnd_act = wide ? opnd : {{(W-B){1'b0}}, opnd[B-1:0]};

    always_comb begin
        res = ta;
        cy  = flags_in.CY;
        ac  = flags_in.AC;
        v   = flags_in.V;
        psz = 1'b1;
        case (operation)
            alu_pkg::ALU_OP_ADD,
            alu_pkg::ALU_OP_ADDC,
            alu_pkg::ALU_OP_INC: begin
                res = sum[W-1:0];
                if (operation != alu_pkg::ALU_OP_INC)
                    cy = wide ? sum[W] : sum[B];   // INC keeps CY
                ac = nib_sum[4];                     // Low nibbles past 15
                v  = (alu_pkg::msb(ta, wide) ^ alu_pkg::msb(res, wide)) &
                     (alu_pkg::msb(opnd, wide) ^ alu_pkg::msb(res, wide));
            end
            alu_pkg::ALU_OP_SUB,
            alu_pkg::ALU_OP_SUBC,
            alu_pkg::ALU_OP_CMP,
            alu_pkg::ALU_OP_DEC: begin
                res = diff;                          // CMP also returns the difference
                if (operation != alu_pkg::ALU_OP_DEC)
                    cy = opnd_act > ta_act;          // Borrow
                ac = opnd[3:0] > ta[3:0];
                v  = (alu_pkg::msb(ta, wide) ^ alu_pkg::msb(opnd, wide)) &
                     (alu_pkg::msb(ta, wide) ^ alu_pkg::msb(res, wide));
            end
            alu_pkg::ALU_OP_NEG: begin
                res = neg;
                cy  = ta_act != '0;
                ac  = ta[3:0] != 4'd0;
                // Only the most negative value overflows
                v   = wide ? (ta == 16'h8000) : (ta[B-1:0] == 8'h80);
            end
            default: psz = 1'b0;                     // Not an arithmetic operation
        endcase
    end

endmodule

`default_nettype wire

// File: logic/alu_bitwise.sv
`timescale 1ns/1ps
`default_nettype none

module alu_bitwise (
    input  wire alu_pkg::alu_op_e               operation,
    input  wire [alu_pkg::WORD_W-1:0]           ta,
    input  wire [alu_pkg::WORD_W-1:0]           tb,
    input  wire                                 wide,
    input  wire alu_pkg::flags_t                flags_in,
    output logic [alu_pkg::WORD_W-1:0]          res,
    output logic                                cy,
    output logic                                ac,
    output logic                                v,
    output logic                                psz
);

    localparam int W = alu_pkg::WORD_W;

    logic [W-1:0] bit_mask;   // One-hot position for the single-bit ops
    logic [3:0]   bit_pos;

    // Narrow mode ignores bit 3 of the position
    assign bit_pos  = wide ? tb[3:0] : {1'b0, tb[2:0]};
    assign bit_mask = W'(1) << bit_pos;

    always_comb begin
        res = ta;
        cy  = flags_in.CY;
        ac  = flags_in.AC;
        v   = flags_in.V;
        psz = 1'b0;
        case (operation)
            alu_pkg::ALU_OP_AND,
            alu_pkg::ALU_OP_OR,
            alu_pkg::ALU_OP_XOR: begin
                if (operation == alu_pkg::ALU_OP_AND)
                    res = ta & tb;
                else if (operation == alu_pkg::ALU_OP_OR)
                    res = ta | tb;
                else
                    res = ta ^ tb;
                cy  = 1'b0;
                ac  = 1'b0;
                v   = 1'b0;
                psz = 1'b1;
            end
            alu_pkg::ALU_OP_NOT:   res = ~ta;              // Flags untouched
            alu_pkg::ALU_OP_SET1:  res = ta | bit_mask;
            alu_pkg::ALU_OP_CLR1:  res = ta & ~bit_mask;
            alu_pkg::ALU_OP_NOT1:  res = ta ^ bit_mask;
            alu_pkg::ALU_OP_TEST1: begin
                // Z ends up set when the tested bit is clear
                res = ta & bit_mask;
                cy  = 1'b0;
                v   = 1'b0;
                psz = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/alu_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module alu_shifter (
    input  wire alu_pkg::alu_op_e               operation,
    input  wire [alu_pkg::WORD_W-1:0]           ta,
    input  wire [alu_pkg::WORD_W-1:0]           tb,
    input  wire                                 wide,
    input  wire alu_pkg::flags_t                flags_in,
    output logic [alu_pkg::WORD_W-1:0]          res,
    output logic                                cy,
    output logic                                ac,
    output logic                                v,
    output logic                                psz
);

    localparam int W = alu_pkg::WORD_W;
    localparam int B = alu_pkg::BYTE_W;

    logic [4:0]          cnt;
    logic [3:0]          rot_amt;       // Count modulo the active width
    logic                cnt_zero;
    logic                cnt_over;      // Every bit already shifted out
    logic [2*W-1:0]      rol_w, ror_w;
    logic [2*B-1:0]      rol_n, ror_n;
    logic [W:0]          shl_w, shr_w;
    logic [B:0]          shl_n, shr_n;
    logic signed [W:0]   sra_w;
    logic signed [B:0]   sra_n;

    assign cnt      = tb[4:0];
    assign rot_amt  = wide ? cnt[3:0] : {1'b0, cnt[2:0]};
    assign cnt_zero = cnt == 5'd0;
    assign cnt_over = wide ? (cnt > 5'd16) : (cnt > 5'd8);

    // Rotates on a doubled copy of the operand
    assign rol_w = {ta, ta} << rot_amt;
    assign ror_w = {ta, ta} >> rot_amt;
    assign rol_n = {ta[B-1:0], ta[B-1:0]} << rot_amt[2:0];
    assign ror_n = {ta[B-1:0], ta[B-1:0]} >> rot_amt[2:0];

    // One spare bit catches the last bit shifted out
    assign shl_w = {1'b0, ta} << cnt;
    assign shl_n = {1'b0, ta[B-1:0]} << cnt;
    assign shr_w = {ta, 1'b0} >> cnt;
    assign shr_n = {ta[B-1:0], 1'b0} >> cnt;
    assign sra_w = $signed({ta, 1'b0}) >>> cnt;
    assign sra_n = $signed({ta[B-1:0], 1'b0}) >>> cnt;

    always_comb begin
        res = ta;
        cy  = flags_in.CY;
        ac  = flags_in.AC;
        v   = flags_in.V;
        psz = 1'b0;
        case (operation)
            alu_pkg::ALU_OP_ROL: begin
                res = wide ? rol_w[2*W-1:W] : {{(W-B){1'b0}}, rol_n[2*B-1:B]};
                if (!cnt_zero)
                    cy = res[0];                        // Last bit out lands in bit 0
                v = alu_pkg::msb(ta, wide) ^ alu_pkg::msb(res, wide);
            end
            alu_pkg::ALU_OP_ROR: begin
                res = wide ? ror_w[W-1:0] : {{(W-B){1'b0}}, ror_n[B-1:0]};
                if (!cnt_zero)
                    cy = alu_pkg::msb(res, wide);      // Last bit out lands on top
                v = alu_pkg::msb(ta, wide) ^ alu_pkg::msb(res, wide);
            end
            alu_pkg::ALU_OP_SHL: begin
                res = wide ? shl_w[W-1:0] : {{(W-B){1'b0}}, shl_n[B-1:0]};
                if (!cnt_zero)
                    cy = wide ? shl_w[W] : shl_n[B];
                v   = alu_pkg::msb(ta, wide) ^ alu_pkg::msb(res, wide);
                psz = 1'b1;
            end
            alu_pkg::ALU_OP_SHR: begin
                res = wide ? shr_w[W:1] : {{(W-B){1'b0}}, shr_n[B:1]};
                if (!cnt_zero)
                    cy = wide ? shr_w[0] : shr_n[0];
                v   = alu_pkg::msb(ta, wide) ^ alu_pkg::msb(res, wide);
                psz = 1'b1;
            end
            alu_pkg::ALU_OP_SHRA: begin
                res = wide ? sra_w[W:1] : {{(W-B){1'b0}}, sra_n[B:1]};
                // Sign copies past the width do not count as shifted out
                if (!cnt_zero)
                    cy = cnt_over ? 1'b0 : (wide ? sra_w[0] : sra_n[0]);
                v   = 1'b0;
                psz = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/alu_result.sv
`timescale 1ns/1ps
`default_nettype none

module alu_result (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire                                 ce,
    input  wire                                 execute,
    input  wire alu_pkg::alu_op_e               operation,
    input  wire                                 wide,
    input  wire alu_pkg::flags_t                flags_in,
    input  wire [alu_pkg::WORD_W-1:0]           arith_res,
    input  wire                                 arith_cy,
    input  wire                                 arith_ac,
    input  wire                                 arith_v,
    input  wire                                 arith_psz,
    input  wire [alu_pkg::WORD_W-1:0]           bit_res,
    input  wire                                 bit_cy,
    input  wire                                 bit_ac,
    input  wire                                 bit_v,
    input  wire                                 bit_psz,
    input  wire [alu_pkg::WORD_W-1:0]           shift_res,
    input  wire                                 shift_cy,
    input  wire                                 shift_ac,
    input  wire                                 shift_v,
    input  wire                                 shift_psz,
    output logic [alu_pkg::WORD_W-1:0]          result,
    output alu_pkg::flags_t                     flags
);

    localparam int W = alu_pkg::WORD_W;
    localparam int B = alu_pkg::BYTE_W;

    alu_pkg::alu_class_e cls;
    logic [W-1:0]        sel_res;
    logic                sel_cy;
    logic                sel_ac;
    logic                sel_v;
    logic                sel_psz;
    logic [W-1:0]        res_act;     // Result cut to the active width
    alu_pkg::flags_t     next_flags;
    logic                accept;

    assign cls = alu_pkg::op_class(operation);

    always_comb begin
        case (cls)
            alu_pkg::CLASS_ARITH: begin
                sel_res = arith_res;
                sel_cy  = arith_cy;
                sel_ac  = arith_ac;
                sel_v   = arith_v;
                sel_psz = arith_psz;
            end
            alu_pkg::CLASS_BITWISE: begin
                sel_res = bit_res;
                sel_cy  = bit_cy;
                sel_ac  = bit_ac;
                sel_v   = bit_v;
                sel_psz = bit_psz;
            end
            alu_pkg::CLASS_SHIFT: begin
                sel_res = shift_res;
                sel_cy  = shift_cy;
                sel_ac  = shift_ac;
                sel_v   = shift_v;
                sel_psz = shift_psz;
            end
            default: begin                    // Illegal code, never loaded
                sel_res = '0;
                sel_cy  = flags_in.CY;
                sel_ac  = flags_in.AC;
                sel_v   = flags_in.V;
                sel_psz = 1'b0;
            end
        endcase
    end

    assign res_act = wide ? sel_res : {{(W-B){1'b0}}, sel_res[B-1:0]};

    always_comb begin
        next_flags.V  = sel_v;
        next_flags.AC = sel_ac;
        next_flags.CY = sel_cy;
        // Parity looks at the low byte only, even count gives 1
        next_flags.P  = sel_psz ? ~^res_act[B-1:0] : flags_in.P;
        next_flags.S  = sel_psz ? alu_pkg::msb(res_act, wide) : flags_in.S;
        next_flags.Z  = sel_psz ? (res_act == '0) : flags_in.Z;
    end

    assign accept = ce && execute && (cls != alu_pkg::CLASS_NONE);

    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
            flags  <= '0;
        end else if (accept) begin
            result <= res_act;
            flags  <= next_flags;
        end
    end

endmodule

`default_nettype wire

// File: logic/alu_top.sv
`timescale 1ns/1ps
`default_nettype none

module alu_top (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire                                 ce,
    input  wire                                 execute,
    input  wire alu_pkg::alu_op_e               operation,
    input  wire [alu_pkg::WORD_W-1:0]           ta,
    input  wire [alu_pkg::WORD_W-1:0]           tb,
    input  wire                                 wide,
    input  wire alu_pkg::flags_t                flags_in,
    output logic [alu_pkg::WORD_W-1:0]          result,
    output alu_pkg::flags_t                     flags
);

    logic [alu_pkg::WORD_W-1:0] arith_res, bit_res, shift_res;
    logic arith_cy, arith_ac, arith_v, arith_psz;
    logic bit_cy, bit_ac, bit_v, bit_psz;
    logic shift_cy, shift_ac, shift_v, shift_psz;

    // Add, subtract and negate family
    alu_addsub i_addsub (
        .operation (operation),
        .ta        (ta),
        .tb        (tb),
        .wide      (wide),
        .flags_in  (flags_in),
        .res       (arith_res),
        .cy        (arith_cy),
        .ac        (arith_ac),
        .v         (arith_v),
        .psz       (arith_psz)
    );

    alu_bitwise i_bitwise (
        .operation (operation),
        .ta        (ta),
        .tb        (tb),
        .wide      (wide),
        .flags_in  (flags_in),
        .res       (bit_res),
        .cy        (bit_cy),
        .ac        (bit_ac),
        .v         (bit_v),
        .psz       (bit_psz)
    );

    alu_shifter i_shifter (
        .operation (operation),
        .ta        (ta),
        .tb        (tb),
        .wide      (wide),
        .flags_in  (flags_in),
        .res       (shift_res),
        .cy        (shift_cy),
        .ac        (shift_ac),
        .v         (shift_v),
        .psz       (shift_psz)
    );

    // Unit select, P/S/Z and the output registers
    alu_result i_result (
        .clk       (clk),
        .reset     (reset),
        .ce        (ce),
        .execute   (execute),
        .operation (operation),
        .wide      (wide),
        .flags_in  (flags_in),
        .arith_res (arith_res),
        .arith_cy  (arith_cy),
        .arith_ac  (arith_ac),
        .arith_v   (arith_v),
        .arith_psz (arith_psz),
        .bit_res   (bit_res),
        .bit_cy    (bit_cy),
        .bit_ac    (bit_ac),
        .bit_v     (bit_v),
        .bit_psz   (bit_psz),
        .shift_res (shift_res),
        .shift_cy  (shift_cy),
        .shift_ac  (shift_ac),
        .shift_v   (shift_v),
        .shift_psz (shift_psz),
        .result    (result),
        .flags     (flags)
    );

endmodule

`default_nettype wire

// File: sim/alu_chk.sv
`timescale 1ns/1ps
`default_nettype none

module alu_chk (
    input wire                          clk,
    input wire                          reset,
    input wire                          ce,
    input wire                          execute,
    input wire alu_pkg::alu_op_e        operation,
    input wire                          wide,
    input wire                          psz,
    input wire [alu_pkg::WORD_W-1:0]    result,
    input wire alu_pkg::flags_t         flags
);

    int   assert_errors = 0;    // Failed assertion count
    logic accepted;

    assign accepted = ce && execute && (alu_pkg::op_class(operation) != alu_pkg::CLASS_NONE);

    // Registers only move on an accepted operation
    hold_check: assert property (@(posedge clk) disable iff (reset)
        !accepted |=> ($stable(result) && $stable(flags)))
    else begin
        assert_errors++;
        $error("result or flags changed without an accepted operation");
    end

    narrow_check: assert property (@(posedge clk) disable iff (reset)
        accepted && !wide |=> (result[15:8] == 8'h00))
    else begin
        assert_errors++;
        $error("upper result byte not zero after a narrow operation");
    end

    // Z tracks the stored result whenever P, S and Z are recomputed
    zero_check: assert property (@(posedge clk) disable iff (reset)
        accepted && psz |=> (flags.Z == (result == '0)))
    else begin
        assert_errors++;
        $error("Z flag does not match the zero test of the result");
    end

endmodule

bind alu_result alu_chk i_chk (
    .clk       (clk),
    .reset     (reset),
    .ce        (ce),
    .execute   (execute),
    .operation (operation),
    .wide      (wide),
    .psz       (sel_psz),
    .result    (result),
    .flags     (flags)
);

`default_nettype wire

// File: sim/alu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module alu_tb;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  ce;
    logic                  execute;
    logic                  wide;
    alu_pkg::alu_op_e      operation;
    logic [15:0]           ta;
    logic [15:0]           tb;
    logic [15:0]           result;
    alu_pkg::flags_t       flags_in;
    alu_pkg::flags_t       flags;

    // Test table, one entry per row
    logic [4:0]  t_op    [0:47];
    logic [15:0] t_ta    [0:47];
    logic [15:0] t_tb    [0:47];
    logic        t_wide  [0:47];
    logic [5:0]  t_fin   [0:47];
    logic        t_ce    [0:47];
    logic        t_ex    [0:47];
    logic [15:0] t_res   [0:47];
    logic [5:0]  t_flags [0:47];   // V S Z AC P CY

    int   n_rows;
    int   n_pass;
    int   n_fail;
    int   wait_cnt;
    int   i;
    logic timed_out;

    always #2 clk = ~clk;          // 4 ns period

    alu_top i_dut (
        .clk       (clk),
        .reset     (reset),
        .ce        (ce),
        .execute   (execute),
        .operation (operation),
        .ta        (ta),
        .tb        (tb),
        .wide      (wide),
        .flags_in  (flags_in),
        .result    (result),
        .flags     (flags)
    );

    task automatic add_row(input logic [4:0] op, input logic [15:0] a, input logic [15:0] b,
                           input logic w, input logic [5:0] fin, input logic c, input logic e,
                           input logic [15:0] r, input logic [5:0] f);
        t_op[n_rows]    = op;
        t_ta[n_rows]    = a;
        t_tb[n_rows]    = b;
        t_wide[n_rows]  = w;
        t_fin[n_rows]   = fin;
        t_ce[n_rows]    = c;
        t_ex[n_rows]    = e;
        t_res[n_rows]   = r;
        t_flags[n_rows] = f;
        n_rows++;
    endtask

    // Logic ops clear CY, AC and V; P, S and Z follow the result
    function automatic logic [21:0] logic_expect(input logic [1:0] sel, input logic [15:0] a,
                                                 input logic [15:0] b, input logic w);
        logic [15:0] r;
        logic [5:0]  f;
        case (sel)
            2'd0:    r = a & b;
            2'd1:    r = a | b;
            default: r = a ^ b;
        endcase
        if (!w)
            r[15:8] = 8'h00;
        f = {1'b0, (w ? r[15] : r[7]), (r == 16'h0000), 1'b0, ~^r[7:0], 1'b0};
        return {r, f};
    endfunction

    task automatic build_table();
        logic [15:0] a;
        logic [15:0] b;
        logic        w;
        logic [5:0]  fin;
        logic [4:0]  rop;
        logic [21:0] exp_val;
        // Add and subtract family
        add_row(alu_pkg::ALU_OP_ADD,  'h00F0, 'h0020, 0, 6'b000000, 1, 1, 'h0010, 6'b000001);
        add_row(alu_pkg::ALU_OP_ADD,  'hFFFF, 'h0001, 1, 6'b000000, 1, 1, 'h0000, 6'b001111);
        add_row(alu_pkg::ALU_OP_ADDC, 'h1234, 'h1111, 1, 6'b000001, 1, 1, 'h2346, 6'b000000);
        add_row(alu_pkg::ALU_OP_SUB,  'h8000, 'h0001, 1, 6'b000000, 1, 1, 'h7FFF, 6'b100110);
        add_row(alu_pkg::ALU_OP_SUB,  'h0050, 'h00B0, 0, 6'b000000, 1, 1, 'h00A0, 6'b110011);
        add_row(alu_pkg::ALU_OP_SUBC, 'h0005, 'h0003, 0, 6'b000001, 1, 1, 'h0001, 6'b000000);
        add_row(alu_pkg::ALU_OP_INC,  'h00FF, 'h5555, 1, 6'b000001, 1, 1, 'h0100, 6'b000111);
        add_row(alu_pkg::ALU_OP_DEC,  'h0000, 'h5555, 0, 6'b000000, 1, 1, 'h00FF, 6'b010110);
        add_row(alu_pkg::ALU_OP_NEG,  'h8000, 'h0000, 1, 6'b000000, 1, 1, 'h8000, 6'b110011);
        add_row(alu_pkg::ALU_OP_NEG,  'h0000, 'h0000, 1, 6'b000001, 1, 1, 'h0000, 6'b001010);
        add_row(alu_pkg::ALU_OP_CMP,  'h0010, 'h0020, 1, 6'b000000, 1, 1, 'hFFF0, 6'b010011);
        // Logic and single-bit ops
        add_row(alu_pkg::ALU_OP_AND,  'hF0F0, 'h3C3C, 1, 6'b100111, 1, 1, 'h3030, 6'b000010);
        add_row(alu_pkg::ALU_OP_OR,   'hAB01, 'h0080, 0, 6'b000001, 1, 1, 'h0081, 6'b010010);
        add_row(alu_pkg::ALU_OP_XOR,  'h5A5A, 'h5A5A, 1, 6'b100101, 1, 1, 'h0000, 6'b001010);
        add_row(alu_pkg::ALU_OP_NOT,  'h00FF, 'h0000, 1, 6'b101101, 1, 1, 'hFF00, 6'b101101);
        add_row(alu_pkg::ALU_OP_SET1, 'h0001, 'h000F, 1, 6'b010010, 1, 1, 'h8001, 6'b010010);
        add_row(alu_pkg::ALU_OP_CLR1, 'hFFFF, 'h000F, 1, 6'b000001, 1, 1, 'h7FFF, 6'b000001);
        add_row(alu_pkg::ALU_OP_NOT1, 'h0000, 'h000B, 0, 6'b001000, 1, 1, 'h0008, 6'b001000);
        add_row(alu_pkg::ALU_OP_TEST1, 'h00F7, 'h0003, 1, 6'b100101, 1, 1, 'h0000, 6'b001110);
        add_row(alu_pkg::ALU_OP_TEST1, 'h0080, 'h000F, 0, 6'b000000, 1, 1, 'h0080, 6'b010000);
        // Rotates and shifts
        add_row(alu_pkg::ALU_OP_ROL,  'h8001, 'h0001, 1, 6'b000000, 1, 1, 'h0003, 6'b100001);
        add_row(alu_pkg::ALU_OP_ROR,  'h0001, 'h0001, 0, 6'b000100, 1, 1, 'h0080, 6'b100101);
        add_row(alu_pkg::ALU_OP_ROL,  'h0081, 'h0009, 0, 6'b000000, 1, 1, 'h0003, 6'b100001);
        add_row(alu_pkg::ALU_OP_SHL,  'h8001, 'h0001, 1, 6'b000000, 1, 1, 'h0002, 6'b100001);
        add_row(alu_pkg::ALU_OP_SHR,  'h0003, 'h0001, 0, 6'b000000, 1, 1, 'h0001, 6'b000001);
        add_row(alu_pkg::ALU_OP_SHRA, 'h0090, 'h0002, 0, 6'b100001, 1, 1, 'h00E4, 6'b010010);
        add_row(alu_pkg::ALU_OP_SHL,  'h1234, 'h0000, 1, 6'b000001, 1, 1, 'h1234, 6'b000001);
        // Held rows keep the values of the row above
        add_row(alu_pkg::ALU_OP_ADD,  'hFFFF, 'h0001, 1, 6'b000000, 0, 1, 'h1234, 6'b000001);
        add_row(alu_pkg::ALU_OP_XOR,  'h00FF, 'h0F0F, 1, 6'b000000, 1, 0, 'h1234, 6'b000001);
        add_row(5'd25,                'h0001, 'h0001, 1, 6'b000000, 1, 1, 'h1234, 6'b000001);
        add_row(alu_pkg::ALU_OP_SHR,  'hFFFF, 'h0011, 1, 6'b000000, 1, 1, 'h0000, 6'b101010);
        for (int k = 0; k < 6; k++) begin
            a       = 16'($urandom);
            b       = 16'($urandom);
            w       = 1'($urandom);
            fin     = 6'($urandom);
            rop     = (k % 3 == 0) ? alu_pkg::ALU_OP_AND :
                      (k % 3 == 1) ? alu_pkg::ALU_OP_OR : alu_pkg::ALU_OP_XOR;
            exp_val = logic_expect(2'(k % 3), a, b, w);
            add_row(rop, a, b, w, fin, 1'b1, 1'b1, exp_val[21:6], exp_val[5:0]);
        end
    endtask

    task automatic check_outputs(input string name, input logic [15:0] exp_res,
                                 input logic [5:0] exp_flags);
        logic ok;
        ok = 1'b1;
        if (result !== exp_res) begin
            $display("[ERROR] %0t ns: %s result %h, expected %h", $time, name, result, exp_res);
            ok = 1'b0;
        end
        if (flags !== exp_flags) begin
            $display("[ERROR] %0t ns: %s flags %b, expected %b", $time, name, flags, exp_flags);
            ok = 1'b0;
        end
        if (ok)
            n_pass++;
        else
            n_fail++;
        $display("%s: %s", name, ok ? "ok" : "mismatch");
    endtask

    initial begin
        void'($urandom(46926));
        reset     = 1'b1;
        ce        = 1'b0;
        execute   = 1'b0;
        wide      = 1'b0;
        operation = alu_pkg::ALU_OP_ADD;
        ta        = 16'h0000;
        tb        = 16'h0000;
        flags_in  = '0;
        n_rows    = 0;
        n_pass    = 0;
        n_fail    = 0;
        timed_out = 1'b0;
        build_table();

        repeat (8) @(posedge clk);
        reset <= 1'b0;
        wait_cnt = 0;
        while (reset && wait_cnt < 16) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (reset) begin
            $display("Timeout: reset was still high after 16 cycles");
            timed_out = 1'b1;
        end

        if (!timed_out) begin
            @(negedge clk);
            check_outputs("after reset", 16'h0000, 6'b000000);
            for (i = 0; i < n_rows; i++) begin
                @(posedge clk);
                operation <= alu_pkg::alu_op_e'(t_op[i]);
                ta        <= t_ta[i];
                tb        <= t_tb[i];
                wide      <= t_wide[i];
                flags_in  <= t_fin[i];
                ce        <= t_ce[i];
                execute   <= t_ex[i];
                @(posedge clk);                  // Accepting edge
                @(negedge clk);
                check_outputs($sformatf("test %0d op %0d", i + 1, t_op[i]), t_res[i], t_flags[i]);
            end
        end

        $display("%0d tests, %0d passed, %0d failed, %0d assertion failures",
                 n_pass + n_fail, n_pass, n_fail, i_dut.i_result.i_chk.assert_errors);
        if (timed_out || n_fail != 0 || i_dut.i_result.i_chk.assert_errors != 0)
            $display("=== FAIL ===");
        else
            $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
logic/alu_pkg.sv
logic/alu_addsub.sv
logic/alu_bitwise.sv
logic/alu_shifter.sv
logic/alu_result.sv
logic/alu_top.sv
sim/alu_chk.sv
sim/alu_tb.sv
